// ==== list.f ====
+incdir+tb
rtl/point_pkg.sv
rtl/field_pkg.sv
rtl/point_if.sv
rtl/point_transform.sv
rtl/anchor_gradient.sv
rtl/center_kernel.sv
rtl/field_labeler.sv
rtl/point_classifier_top.sv
tb/tb_point_classifier.sv

// ==== rtl/anchor_gradient.sv ====
`timescale 1ns/1ps

module anchor_gradient
  import point_pkg::*;
  import field_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic   aclk,
  input  logic   aresetn,
  point_if.dst   pts,
  output field_t grad_sum
);

  logic [$clog2(ANCHOR_NUM)-1:0] anc_cnt;
  logic   anc_wr;
  coord_t anc     [ANCHOR_NUM][AXIS_NUM];
  dist_t  dist_r  [ANCHOR_NUM];
  diff_t  diff_r  [ANCHOR_NUM][AXIS_NUM];   // anchor minus point
  field_t grad_acc;

  assign anc_wr = pts.valid && (pts.phase == phase_anchor);

  // ----------------------------------------
  // anchor store, arrival order
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      anc_cnt <= '0;
    end else if (anc_wr) begin
      anc_cnt <= (anc_cnt == ($bits(anc_cnt))'(ANCHOR_NUM - 1)) ? '0 : anc_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (anc_wr) begin
      anc[anc_cnt][0] <= pts.x;
      anc[anc_cnt][1] <= pts.y;
      anc[anc_cnt][2] <= pts.z;
    end
  end

  // stage 1: distance and differences per anchor
  always_ff @(posedge aclk) begin
    for (int k = 0; k < ANCHOR_NUM; k++) begin
      dist_r[k]    <= manhattan(anc[k][0], anc[k][1], anc[k][2], pts.x, pts.y, pts.z);
      diff_r[k][0] <= anc[k][0] - pts.x;
      diff_r[k][1] <= anc[k][1] - pts.y;
      diff_r[k][2] <= anc[k][2] - pts.z;
    end
  end

  // ----------------------------------------
  // stage 2: weighted gradient sum
  // ----------------------------------------
  always_comb begin
    logic signed [36:0] gd;  // distance times difference
    logic signed [49:0] gw;  // weight times scaled term
    grad_acc = '0;
    for (int k = 0; k < ANCHOR_NUM; k++) begin
      for (int a = 0; a < AXIS_NUM; a++) begin
        gd = $signed({1'b0, dist_r[k]}) * diff_r[k][a];
        gw = W_GRAD[k*AXIS_NUM + a] * field_t'(gd >>> FRAC_BITS);
        grad_acc += field_t'(gw >>> FRAC_BITS);  // wraps at 32 bits
      end
    end
  end

  always_ff @(posedge aclk) begin
    grad_sum <= grad_acc;
  end

endmodule

// ==== rtl/center_kernel.sv ====
`timescale 1ns/1ps

module center_kernel
  import point_pkg::*;
  import field_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic   aclk,
  input  logic   aresetn,
  point_if.dst   pts,
  output field_t kern_sum
);

  // kernel pairs behind each W_KDIFF entry
  localparam int KD_A [4] = '{0, 0, 3, 3};
  localparam int KD_B [4] = '{1, 2, 4, 5};

  logic [$clog2(CENTER_NUM)-1:0] ctr_cnt;
  logic   ctr_wr;
  logic   ctr_full;  // all six centers of this frame stored
  coord_t ctr    [CENTER_NUM][AXIS_NUM];
  dist_t  kern_r [CENTER_NUM];
  field_t kern_acc;

  assign ctr_wr = pts.valid && (pts.phase == phase_center);

  // ----------------------------------------
  // center store
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ctr_cnt  <= '0;
      ctr_full <= 1'b0;
    end else if (ctr_wr) begin
      ctr_cnt <= (ctr_cnt == ($bits(ctr_cnt))'(CENTER_NUM - 1)) ? '0 : ctr_cnt + 1'b1;
      if (ctr_cnt == ($bits(ctr_cnt))'(CENTER_NUM - 1)) ctr_full <= 1'b1;
    end else if (pts.valid && pts.phase == phase_anchor) begin
      ctr_full <= 1'b0;  // new frame setup
    end
  end

  always_ff @(posedge aclk) begin
    if (ctr_wr) begin
      ctr[ctr_cnt][0] <= pts.x;
      ctr[ctr_cnt][1] <= pts.y;
      ctr[ctr_cnt][2] <= pts.z;
    end
  end

  // stage 1: kernel values
  always_ff @(posedge aclk) begin
    for (int j = 0; j < CENTER_NUM; j++) begin
      kern_r[j] <= manhattan(pts.x, pts.y, pts.z, ctr[j][0], ctr[j][1], ctr[j][2]);
    end
  end

  // ----------------------------------------
  // stage 2: weighted kernel differences
  // ----------------------------------------
  always_comb begin
    logic signed [19:0] kd;
    logic signed [37:0] kp;
    kern_acc = '0;
    for (int i = 0; i < 4; i++) begin
      kd = $signed({1'b0, kern_r[KD_A[i]]}) - $signed({1'b0, kern_r[KD_B[i]]});
      kp = W_KDIFF[i] * kd;
      kern_acc += field_t'(kp >>> FRAC_BITS);
    end
  end

  always_ff @(posedge aclk) begin
    kern_sum <= kern_acc;
  end

  a_centers_loaded : assert property (@(posedge aclk) disable iff (!aresetn)
    pts.valid && pts.phase == phase_score |-> ctr_full)
    else $error("scored point before six centers were stored");

endmodule

// ==== rtl/field_labeler.sv ====
`timescale 1ns/1ps

module field_labeler
  import point_pkg::*;
  import field_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic        aclk,
  input  logic        aresetn,
  point_if.dst        pts,
  input  field_t      grad_sum,
  input  field_t      kern_sum,
  output logic [63:0] m_tdata,
  output logic        m_tvalid,
  output logic        m_tlast
);

  coord_t     pt_d [2][AXIS_NUM];  // point delayed to meet the branch sums
  logic [1:0] v_d, l_d;
  field_t     lin_acc;
  field_t     field_r;
  logic       fv, fl;
  field_t     t1, t2;
  logic [1:0] score_cnt;           // 0 and 1 pick thresholds, 2 labels
  label_t     label_nx, label_r;

  // ----------------------------------------
  // two-cycle delay of the scored point
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    pt_d[0] <= '{pts.x, pts.y, pts.z};
    pt_d[1] <= pt_d[0];
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      v_d <= '0;
      l_d <= '0;
    end else begin
      v_d <= {v_d[0], pts.valid && pts.phase == phase_score};
      l_d <= {l_d[0], pts.last};
    end
  end

  always_comb begin
    logic signed [33:0] lp;
    lin_acc = '0;
    for (int a = 0; a < AXIS_NUM; a++) begin
      lp = W_LIN[a] * pt_d[1][a];
      lin_acc += field_t'(lp >>> FRAC_BITS);
    end
  end

  // stage 1: field value
  always_ff @(posedge aclk) begin
    field_r <= grad_sum + kern_sum + lin_acc;  // wrapped 32-bit sum
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      fv <= 1'b0;
      fl <= 1'b0;
    end else begin
      fv <= v_d[1];
      fl <= l_d[1];
    end
  end

  // ----------------------------------------
  // stage 2: thresholds and label
  // ----------------------------------------
  assign label_nx = (field_r <= t1) ? 3'd3 : (field_r <= t2) ? 3'd2 : 3'd1;

  always_ff @(posedge aclk) begin
    if (fv && score_cnt == 2'd0) t1 <= field_r;
    if (fv && score_cnt == 2'd1) t2 <= field_r;
    label_r <= label_nx;
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      score_cnt <= '0;
      m_tvalid  <= 1'b0;
      m_tlast   <= 1'b0;
    end else begin
      m_tvalid <= fv && score_cnt == 2'd2;
      m_tlast  <= fv && fl && score_cnt == 2'd2;
      if (fv) begin
        if (fl) score_cnt <= '0;  // frame done
        else if (score_cnt != 2'd2) score_cnt <= score_cnt + 2'd1;
      end
    end
  end

  assign m_tdata = {{(64 - $bits(label_t)){1'b0}}, label_r};

  a_last_has_valid : assert property (@(posedge aclk) disable iff (!aresetn)
    m_tlast |-> m_tvalid)
    else $error("m_tlast without m_tvalid");

endmodule

// ==== rtl/field_pkg.sv ====
package field_pkg;

  typedef logic signed [31:0] field_t;   // field value, partial sum, threshold
  typedef logic signed [17:0] weight_t;
  typedef logic [2:0]         label_t;   // class 1..3

  // ----------------------------------------
  // gradient weights, anchor-major
  // ----------------------------------------
  localparam weight_t W_GRAD [9] = '{
    18'sd45382,  18'sd10644, 18'sd31305,   // anchor 0 x y z
    -18'sd78384, 18'sd5471,  -18'sd15232,  // anchor 1
    -18'sd51078, 18'sd921,   18'sd14713    // anchor 2
  };

  // ----------------------------------------
  // kernel difference weights
  // ----------------------------------------
  localparam weight_t W_KDIFF [4] = '{
    -18'sd49562,  // K0 - K1
    18'sd70757,   // K0 - K2
    -18'sd21096,  // K3 - K4
    18'sd25532    // K3 - K5
  };

  // linear term on the point itself
  localparam weight_t W_LIN [3] = '{
    -18'sd18139,
    -18'sd18746,
    18'sd44106
  };

endpackage

// ==== rtl/point_classifier_top.sv ====
`timescale 1ns/1ps

module point_classifier_top
  import point_pkg::*;
  import field_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic        aclk,
  input  logic        aresetn,
  input  beat_t       s_tdata,
  input  logic        s_tvalid,
  output logic        s_tready,
  input  logic        s_tlast,
  output logic [63:0] m_tdata,
  output logic        m_tvalid,
  output logic        m_tlast
);

  field_t grad_sum;  // anchor branch
  field_t kern_sum;  // center branch

  point_if pif0 ();

  point_transform #(.FRAC_BITS(FRAC_BITS)) transform0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .pts      (pif0.src)
  );

  anchor_gradient #(.FRAC_BITS(FRAC_BITS)) grad0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .pts      (pif0.dst),
    .grad_sum (grad_sum)
  );

  center_kernel #(.FRAC_BITS(FRAC_BITS)) kern0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .pts      (pif0.dst),
    .kern_sum (kern_sum)
  );

  field_labeler #(.FRAC_BITS(FRAC_BITS)) label0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .pts      (pif0.dst),
    .grad_sum (grad_sum),
    .kern_sum (kern_sum),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast)
  );

endmodule

// ==== rtl/point_if.sv ====
`timescale 1ns/1ps

interface point_if import point_pkg::*; ();

  logic   valid;  // one cycle per point
  coord_t x;
  coord_t y;
  coord_t z;
  phase_e phase;
  logic   last;   // point carried s_tlast

  modport src (
    output valid, x, y, z, phase, last
  );

  modport dst (
    input valid, x, y, z, phase, last
  );

endinterface

// ==== rtl/point_pkg.sv ====
package point_pkg;

  // ----------------------------------------
  // geometry types
  // ----------------------------------------
  typedef logic signed [15:0] coord_t;  // raw or transformed coordinate
  typedef logic signed [16:0] diff_t;   // difference of two coordinates
  typedef logic [18:0]        dist_t;   // sum of three 17-bit magnitudes
  typedef logic [63:0]        beat_t;   // one stream beat

  typedef enum logic [1:0] {
    phase_anchor,
    phase_center,
    phase_score
  } phase_e;

  localparam int LANE_W     = 16;  // bits per lane, lane 0 at the bottom
  localparam int LANE_NUM   = 4;
  localparam int AXIS_NUM   = 3;   // x, y, z
  localparam int ANCHOR_NUM = 3;
  localparam int CENTER_NUM = 6;

  function automatic coord_t beat_lane(input beat_t b, input int idx);
    return coord_t'(b[idx*LANE_W +: LANE_W]);
  endfunction

  // sum of absolute coordinate differences
  function automatic dist_t manhattan(input coord_t ax, input coord_t ay, input coord_t az,
                                      input coord_t bx, input coord_t by, input coord_t bz);
    diff_t       dx, dy, dz;
    logic [16:0] mx, my, mz;
    dx = ax - bx;
    dy = ay - by;
    dz = az - bz;
    mx = dx[16] ? -dx : dx;
    my = dy[16] ? -dy : dy;
    mz = dz[16] ? -dz : dz;
    return dist_t'(mx) + dist_t'(my) + dist_t'(mz);
  endfunction

endpackage

// ==== rtl/point_transform.sv ====
`timescale 1ns/1ps

module point_transform
  import point_pkg::*;
  import field_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic  aclk,
  input  logic  aresetn,
  input  beat_t s_tdata,
  input  logic  s_tvalid,
  output logic  s_tready,
  input  logic  s_tlast,
  point_if.src  pts
);

  typedef enum logic [1:0] {st_matrix, st_anchor, st_center, st_score} state_e;

  state_e     state;
  logic [2:0] beat_cnt;    // beats seen in the current setup phase
  logic       accept;
  phase_e     beat_phase;

  coord_t     mat    [AXIS_NUM][LANE_NUM];
  field_t     prod_r [AXIS_NUM][LANE_NUM];
  coord_t     row_sum [AXIS_NUM];
  logic       v1, last1;
  phase_e     ph1;

  assign s_tready = 1'b1;  // never stalls
  assign accept   = s_tvalid & s_tready;

  // ----------------------------------------
  // frame sequencer
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state    <= st_matrix;
      beat_cnt <= '0;
    end else if (accept) begin
      if (s_tlast) begin
        state    <= st_matrix;  // next frame starts right away
        beat_cnt <= '0;
      end else begin
        case (state)
          st_matrix: begin
            beat_cnt <= (beat_cnt == 3'(AXIS_NUM - 1)) ? '0 : beat_cnt + 3'd1;
            if (beat_cnt == 3'(AXIS_NUM - 1)) state <= st_anchor;
          end
          st_anchor: begin
            beat_cnt <= (beat_cnt == 3'(ANCHOR_NUM - 1)) ? '0 : beat_cnt + 3'd1;
            if (beat_cnt == 3'(ANCHOR_NUM - 1)) state <= st_center;
          end
          st_center: begin
            beat_cnt <= (beat_cnt == 3'(CENTER_NUM - 1)) ? '0 : beat_cnt + 3'd1;
            if (beat_cnt == 3'(CENTER_NUM - 1)) state <= st_score;
          end
          default: beat_cnt <= '0;  // scoring runs until s_tlast
        endcase
      end
    end
  end

  always_comb begin
    case (state)
      st_anchor: beat_phase = phase_anchor;
      st_center: beat_phase = phase_center;
      default:   beat_phase = phase_score;
    endcase
  end

  // matrix rows, one per setup beat
  always_ff @(posedge aclk) begin
    if (accept && state == st_matrix) begin
      for (int c = 0; c < LANE_NUM; c++) begin
        mat[beat_cnt[1:0]][c] <= beat_lane(s_tdata, c);
      end
    end
  end

  // ----------------------------------------
  // stage 1: lane products
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    for (int r = 0; r < AXIS_NUM; r++) begin
      for (int c = 0; c < LANE_NUM; c++) begin
        prod_r[r][c] <= mat[r][c] * beat_lane(s_tdata, c);  // full 32-bit product
      end
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      v1    <= 1'b0;
      last1 <= 1'b0;
      ph1   <= phase_anchor;
    end else begin
      v1    <= accept && (state != st_matrix);  // matrix beats stay internal
      last1 <= accept && s_tlast;
      ph1   <= beat_phase;
    end
  end

  // ----------------------------------------
  // stage 2: row sums onto point_if
  // ----------------------------------------
  always_comb begin
    field_t acc;
    for (int r = 0; r < AXIS_NUM; r++) begin
      acc = '0;
      for (int c = 0; c < LANE_NUM; c++) begin
        acc += prod_r[r][c] >>> FRAC_BITS;
      end
      row_sum[r] = coord_t'(acc);  // wraps to 16 bits
    end
  end

  always_ff @(posedge aclk) begin
    pts.x <= row_sum[0];
    pts.y <= row_sum[1];
    pts.z <= row_sum[2];
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      pts.valid <= 1'b0;
      pts.last  <= 1'b0;
      pts.phase <= phase_anchor;
    end else begin
      pts.valid <= v1;
      pts.last  <= last1;
      pts.phase <= ph1;
    end
  end

  a_last_in_score : assert property (@(posedge aclk) disable iff (!aresetn)
    s_tvalid && s_tlast |-> state == st_score)
    else $error("s_tlast accepted outside the scoring phase");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the point classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_point_classifier -f list.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// ==== tb/classifier_model.svh ====
`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// reference model of the classifier, included inside the testbench module
// uses the point_pkg and field_pkg types imported by the enclosing module

// each row applied to all four lanes, product shifted, row sum kept to 16 bits
function automatic vec3_t transform_point(input mat_t m, input beat_t raw);
  vec3_t  p;
  longint acc;
  for (int r = 0; r < 3; r++) begin
    acc = 0;
    for (int c = 0; c < 4; c++) begin
      acc += (longint'($signed(m[r][16*c +: 16])) * longint'($signed(raw[16*c +: 16])))
             >>> FRAC_BITS;
    end
    p[r] = acc[15:0];
  end
  return p;
endfunction

function automatic int l1_dist(input vec3_t a, input vec3_t b);
  int sum;
  int d;
  sum = 0;
  for (int i = 0; i < 3; i++) begin
    d = int'($signed(a[i])) - int'($signed(b[i]));
    sum += (d < 0) ? -d : d;
  end
  return sum;
endfunction

// anchor gradient terms, anchor-major then x y z
function automatic field_t gradient_part(input anc_set_t an, input vec3_t p);
  field_t acc;
  field_t scaled;
  longint gd;
  longint gw;
  int     d;
  int     diff;
  acc = 0;
  for (int k = 0; k < ANCHOR_NUM; k++) begin
    d = l1_dist(an[k], p);
    for (int a = 0; a < 3; a++) begin
      diff   = int'($signed(an[k][a])) - int'($signed(p[a]));  // anchor minus point
      gd     = longint'(d) * longint'(diff);
      scaled = field_t'(gd >>> FRAC_BITS);
      gw     = longint'(W_GRAD[k*3 + a]) * longint'(scaled);
      acc   += field_t'(gw >>> FRAC_BITS);
    end
  end
  return acc;
endfunction

function automatic field_t kernel_part(input ctr_set_t ct, input vec3_t p);
  field_t acc;
  int     kv [CENTER_NUM];
  int     kd [4];
  for (int j = 0; j < CENTER_NUM; j++) begin
    kv[j] = l1_dist(p, ct[j]);
  end
  kd[0] = kv[0] - kv[1];
  kd[1] = kv[0] - kv[2];
  kd[2] = kv[3] - kv[4];
  kd[3] = kv[3] - kv[5];
  acc = 0;
  for (int i = 0; i < 4; i++) begin
    acc += field_t'((longint'(W_KDIFF[i]) * longint'(kd[i])) >>> FRAC_BITS);
  end
  return acc;
endfunction

function automatic field_t linear_part(input vec3_t p);
  field_t acc;
  acc = 0;
  for (int a = 0; a < 3; a++) begin
    acc += field_t'((longint'(W_LIN[a]) * longint'($signed(p[a]))) >>> FRAC_BITS);
  end
  return acc;
endfunction

function automatic field_t field_value(input anc_set_t an, input ctr_set_t ct, input vec3_t p);
  return gradient_part(an, p) + kernel_part(ct, p) + linear_part(p);  // wraps at 32 bits
endfunction

function automatic label_t label_for(input field_t f, input field_t t1, input field_t t2);
  if (f <= t1) return 3'd3;
  else if (f <= t2) return 3'd2;
  else return 3'd1;
endfunction

`endif

// ==== tb/tb_point_classifier.sv ====
`timescale 1ns/1ps

module tb_point_classifier
  import point_pkg::*;
  import field_pkg::*;
();

  localparam int        FRAC_BITS   = 8;
  localparam int        FRAMES      = 4;
  localparam int        SCORED [FRAMES] = '{10, 16, 7, 24};  // scored points per frame
  localparam int        SETUP_BEATS = 3 + ANCHOR_NUM + CENTER_NUM;
  localparam int        LATENCY     = 6;
  localparam bit [31:0] SEED        = 32'ha622_8c39;

  typedef logic [2:0][15:0]                 vec3_t;  // x y z
  typedef logic [2:0][63:0]                 mat_t;   // one beat per matrix row
  typedef logic [ANCHOR_NUM-1:0][2:0][15:0] anc_set_t;
  typedef logic [CENTER_NUM-1:0][2:0][15:0] ctr_set_t;

  typedef struct packed {
    label_t label;
    logic   last;
    int     acc_cyc;  // edge that accepted the point beat
  } exp_t;

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int f = 0; f < FRAMES; f++) begin
      sum += SETUP_BEATS + SCORED[f];
    end
    return sum;
  endfunction

  localparam int TIMEOUT_CYC = total_beats() * 2 + 100;  // gaps at most double a frame

  logic        aclk;
  logic        aresetn;
  beat_t       s_tdata;
  logic        s_tvalid;
  logic        s_tready;
  logic        s_tlast;
  logic [63:0] m_tdata;
  logic        m_tvalid;
  logic        m_tlast;

  int       cyc = 0;
  int       label_cnt = 0;
  exp_t     exp_q [$];
  mat_t     mat_m;
  anc_set_t anc_m;
  ctr_set_t ctr_m;

  `include "classifier_model.svh"

  point_classifier_top #(.FRAC_BITS(FRAC_BITS)) dut0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast)
  );

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;  // 8 ns period

  // ----------------------------------------
  // error handling and compare tasks
  // ----------------------------------------
  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    stop_run();
  endtask

  task automatic check_label(input label_t got, input label_t want);
    if (got !== want) begin
      $display("FAIL at %0t ns: m_tdata label got %0d, expected %0d", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_last(input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL at %0t ns: m_tlast got %b, expected %b", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_ready(input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL at %0t ns: s_tready got %b, expected %b", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_latency(input int got, input int want);
    if (got != want) begin
      $display("FAIL at %0t ns: m_tvalid latency got %0d, expected %0d", $time, got, want);
      stop_run();
    end
  endtask

  always @(posedge aclk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) fail_run("timeout, not all labels came out in time");
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  function automatic beat_t rand_beat();
    beat_t b;
    for (int c = 0; c < 4; c++) begin
      b[16*c +: 16] = 16'($urandom_range(0, 1023) - 512);  // 10-bit signed lanes
    end
    return b;
  endfunction

  task automatic send_beat(input beat_t data, input logic last, input bit gaps,
                           output int acc_cyc);
    if (gaps && $urandom_range(0, 1) == 1) begin
      @(posedge aclk);
      s_tvalid <= 1'b0;
      s_tlast  <= 1'b0;
    end
    @(posedge aclk);
    s_tdata  <= data;
    s_tvalid <= 1'b1;
    s_tlast  <= last;
    acc_cyc  = cyc + 2;  // cyc still holds the count before this edge
  endtask

  task automatic run_frame(input int n, input bit gaps);
    beat_t  raw;
    vec3_t  p;
    field_t f;
    field_t t1;
    field_t t2;
    exp_t   e;
    int     acc;
    t1 = '0;
    t2 = '0;
    for (int r = 0; r < 3; r++) begin
      raw = rand_beat();
      mat_m[r] = raw;
      send_beat(raw, 1'b0, gaps, acc);
    end
    for (int k = 0; k < ANCHOR_NUM; k++) begin
      raw = rand_beat();
      anc_m[k] = transform_point(mat_m, raw);
      send_beat(raw, 1'b0, gaps, acc);
    end
    for (int j = 0; j < CENTER_NUM; j++) begin
      raw = rand_beat();
      ctr_m[j] = transform_point(mat_m, raw);
      send_beat(raw, 1'b0, gaps, acc);
    end
    for (int i = 0; i < n; i++) begin
      raw = rand_beat();
      p   = transform_point(mat_m, raw);
      f   = field_value(anc_m, ctr_m, p);
      send_beat(raw, i == n - 1, gaps, acc);
      if (i == 0) begin
        t1 = f;
      end else if (i == 1) begin
        t2 = f;
      end else begin
        e.label   = label_for(f, t1, t2);
        e.last    = (i == n - 1);
        e.acc_cyc = acc;
        exp_q.push_back(e);
      end
    end
  endtask

  // ----------------------------------------
  // output monitor
  // ----------------------------------------
  always @(negedge aclk) begin : out_monitor
    exp_t e;
    if (aresetn) begin
      check_ready(s_tready, 1'b1);  // no back-pressure
      if (m_tlast && !m_tvalid) fail_run("m_tlast is high without m_tvalid");
      if (m_tvalid) begin
        if (exp_q.size() == 0) begin
          fail_run("m_tvalid is high with no scored point pending");
        end else begin
          e = exp_q.pop_front();
          if (m_tdata[63:$bits(label_t)] != '0) fail_run("upper bits of m_tdata are not zero");
          check_label(label_t'(m_tdata[$bits(label_t)-1:0]), e.label);
          check_last(m_tlast, e.last);
          check_latency(cyc + 1 - e.acc_cyc, LATENCY);  // label is taken at the next edge
          label_cnt++;
        end
      end
    end
  end

  initial begin
    int total_labels;
    total_labels = 0;
    void'($urandom(SEED));
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    aresetn  = 1'b0;
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (8) @(posedge aclk);  // idle, no output expected

    // first two frames back to back without gaps
    for (int f = 0; f < FRAMES; f++) begin
      run_frame(SCORED[f], f >= 2);
      total_labels += SCORED[f] - 2;
    end
    @(posedge aclk);
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;

    while (exp_q.size() != 0) @(posedge aclk);
    repeat (12) @(posedge aclk);  // catch stray labels
    if (label_cnt == total_labels) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run("number of labels differs from the scored points minus two per frame");
    end
  end

endmodule
